//--- common/harness_pkg.sv
package harness_pkg;

    // ----------------------------------------------------------------------
    // Sizes

    localparam int word_width      = 36;
    localparam int port_count      = 4;
    localparam int port_idx_width  = 2;

    // Op select, then per side: read flags, write flags, four read words
    localparam int in_frame_width  = 2 + 2 * (port_count * 2 + port_count * word_width);

    // Write data of both sides, then four enable groups
    localparam int out_frame_width = 2 * port_count * word_width + 4 * port_count;

    // Input bit counter
    localparam int bit_count_width = $clog2(in_frame_width);
    localparam logic [bit_count_width-1:0] last_in_bit = bit_count_width'(in_frame_width - 1);

    // ----------------------------------------------------------------------
    // Operation select

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } alu_op_t;

    // ----------------------------------------------------------------------
    // Input frame

    typedef logic [word_width-1:0]     word_t;
    typedef logic [port_count-1:0]     port_flags_t;
    typedef logic [port_idx_width-1:0] port_idx_t;

    typedef struct packed {
        port_flags_t                read_ef;    // 1: port holds data
        port_flags_t                write_ef;   // 1: port is full
        word_t [port_count-1:0]     read_data;  // port 0 in lowest word
    } io_side_t;

    typedef struct packed {
        alu_op_t    op;
        io_side_t   side_a;
        io_side_t   side_b;
    } harness_in_t;

    // ----------------------------------------------------------------------
    // Picker result

    typedef struct packed {
        logic       rd_valid;
        port_idx_t  rd_port;
        word_t      operand;
        logic       wr_valid;
        port_idx_t  wr_port;
    } side_pick_t;

    // ----------------------------------------------------------------------
    // Output frame, first field goes out first

    typedef struct packed {
        word_t [port_count-1:0]     write_data_a;
        word_t [port_count-1:0]     write_data_b;
        port_flags_t                rden_a;
        port_flags_t                rden_b;
        port_flags_t                wren_a;
        port_flags_t                wren_b;
    } harness_out_t;

endpackage

//--- src/harness_input_register.sv
`timescale 1ns/1ps

module harness_input_register (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    test_in,
    output harness_pkg::harness_in_t frame,
    output logic                    frame_strobe
);

    logic [harness_pkg::in_frame_width-1:0]  shift_reg;
    logic [harness_pkg::in_frame_width-1:0]  shift_next;
    logic [harness_pkg::bit_count_width-1:0] bit_count;
    logic                                    last_bit;

    // First bit sampled ends up as the MSB
    assign shift_next = {shift_reg[harness_pkg::in_frame_width-2:0], test_in};
    assign last_bit   = (bit_count == harness_pkg::last_in_bit);

    always_ff @(posedge clock) begin
        shift_reg <= shift_next;
    end

    // ----------------------------------------------------------------------
    // Bit counter and frame capture

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_count <= '0;
        end else if (last_bit) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame        <= '0;
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= last_bit;
            if (last_bit) begin
                frame <= shift_next;
            end
        end
    end

endmodule

//--- src/harness_output_register.sv
`timescale 1ns/1ps

module harness_output_register (
    input  logic                     clock,
    input  logic                     arst_n,
    input  harness_pkg::harness_out_t result,
    input  logic                     result_strobe,
    output logic                     test_out
);

    logic [harness_pkg::out_frame_width-1:0] shift_reg;

    // ----------------------------------------------------------------------
    // Load on strobe, otherwise shift out MSB first with zero fill

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shift_reg <= '0;
        end else if (result_strobe) begin
            shift_reg <= result;
        end else begin
            shift_reg <= {shift_reg[harness_pkg::out_frame_width-2:0], 1'b0};
        end
    end

    assign test_out = shift_reg[harness_pkg::out_frame_width-1];

endmodule

//--- io_core/io_side_picker.sv
`timescale 1ns/1ps

module io_side_picker (
    input  logic                   clock,
    input  logic                   arst_n,
    input  harness_pkg::io_side_t   side,
    input  logic                   frame_strobe,
    output harness_pkg::side_pick_t pick,
    output logic                   pick_strobe
);

    // Index of the lowest set flag, zero when none is set
    function automatic harness_pkg::port_idx_t lowest_set(
        input harness_pkg::port_flags_t flags
    );
        harness_pkg::port_idx_t idx;
        idx = '0;
        for (int i = harness_pkg::port_count - 1; i >= 0; i--) begin
            if (flags[i]) begin
                idx = harness_pkg::port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ----------------------------------------------------------------------
    // Priority choice

    harness_pkg::port_flags_t write_free;
    harness_pkg::side_pick_t  pick_next;

    assign write_free = ~side.write_ef;

    always_comb begin
        pick_next.rd_valid = |side.read_ef;
        pick_next.rd_port  = lowest_set(side.read_ef);
        pick_next.operand  = side.read_data[pick_next.rd_port];
        pick_next.wr_valid = |write_free;
        pick_next.wr_port  = lowest_set(write_free);
    end

    // ----------------------------------------------------------------------
    // Register on frame strobe

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pick        <= '0;
            pick_strobe <= 1'b0;
        end else begin
            pick_strobe <= frame_strobe;
            if (frame_strobe) begin
                pick <= pick_next;
            end
        end
    end

endmodule

//--- io_core/io_combiner.sv
`timescale 1ns/1ps

module io_combiner (
    input  logic                    clock,
    input  logic                    arst_n,
    input  harness_pkg::alu_op_t     op,
    input  harness_pkg::side_pick_t  pick_a,
    input  harness_pkg::side_pick_t  pick_b,
    input  logic                    pick_strobe,
    output harness_pkg::harness_out_t result,
    output logic                    result_strobe
);

    function automatic harness_pkg::word_t alu(
        input harness_pkg::alu_op_t sel,
        input harness_pkg::word_t   x,
        input harness_pkg::word_t   y
    );
        harness_pkg::word_t r;
        case (sel)
            harness_pkg::op_add: r = x + y;
            harness_pkg::op_sub: r = x - y;   // wraps at word width
            harness_pkg::op_and: r = x & y;
            harness_pkg::op_xor: r = x ^ y;
            default:             r = '0;
        endcase
        return r;
    endfunction

    function automatic harness_pkg::port_flags_t one_hot(
        input logic                   en,
        input harness_pkg::port_idx_t idx
    );
        harness_pkg::port_flags_t v;
        v = '0;
        v[idx] = en;
        return v;
    endfunction

    // ----------------------------------------------------------------------
    // Result frame

    logic                      run;
    harness_pkg::word_t        res_ab;
    harness_pkg::word_t        res_ba;
    harness_pkg::harness_out_t result_next;

    assign run    = pick_a.rd_valid & pick_b.rd_valid;
    assign res_ab = alu(op, pick_a.operand, pick_b.operand);
    assign res_ba = alu(op, pick_b.operand, pick_a.operand);

    always_comb begin
        result_next.rden_a = one_hot(pick_a.rd_valid, pick_a.rd_port);
        result_next.rden_b = one_hot(pick_b.rd_valid, pick_b.rd_port);
        result_next.wren_a = one_hot(run & pick_a.wr_valid, pick_a.wr_port);
        result_next.wren_b = one_hot(run & pick_b.wr_valid, pick_b.wr_port);
        // Only the enabled slot carries data
        for (int i = 0; i < harness_pkg::port_count; i++) begin
            result_next.write_data_a[i] = result_next.wren_a[i] ? res_ab : '0;
            result_next.write_data_b[i] = result_next.wren_b[i] ? res_ba : '0;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result        <= '0;
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= pick_strobe;
            if (pick_strobe) begin
                result <= result_next;
            end
        end
    end

endmodule

//--- io_core/io_core.sv
`timescale 1ns/1ps

module io_core (
    input  logic                     clock,
    input  logic                     arst_n,
    input  harness_pkg::harness_in_t  frame,
    input  logic                     frame_strobe,
    output harness_pkg::harness_out_t result,
    output logic                     result_strobe
);

    harness_pkg::side_pick_t pick_a;
    harness_pkg::side_pick_t pick_b;
    logic                    pick_strobe;
    harness_pkg::alu_op_t    op_q;

    // Op follows the picks by one stage
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= harness_pkg::op_add;
        end else if (frame_strobe) begin
            op_q <= frame.op;
        end
    end

    // ----------------------------------------------------------------------
    // Both pickers pulse together, B's strobe is not needed

    io_side_picker side_a_picker (
        .clock        (clock),
        .arst_n       (arst_n),
        .side         (frame.side_a),
        .frame_strobe (frame_strobe),
        .pick         (pick_a),
        .pick_strobe  (pick_strobe)
    );

    io_side_picker side_b_picker (
        .clock        (clock),
        .arst_n       (arst_n),
        .side         (frame.side_b),
        .frame_strobe (frame_strobe),
        .pick         (pick_b),
        .pick_strobe  ()
    );

    io_combiner combiner (
        .clock         (clock),
        .arst_n        (arst_n),
        .op            (op_q),
        .pick_a        (pick_a),
        .pick_b        (pick_b),
        .pick_strobe   (pick_strobe),
        .result        (result),
        .result_strobe (result_strobe)
    );

endmodule

//--- src/test_harness.sv
`timescale 1ns/1ps

module test_harness (
    input  logic clock,
    input  logic arst_n,
    input  logic test_in,
    output logic test_out
);

    harness_pkg::harness_in_t  frame;
    logic                      frame_strobe;
    harness_pkg::harness_out_t result;
    logic                      result_strobe;

    // ----------------------------------------------------------------------
    // Serial in

    harness_input_register input_reg (
        .clock        (clock),
        .arst_n       (arst_n),
        .test_in      (test_in),
        .frame        (frame),
        .frame_strobe (frame_strobe)
    );

    // ----------------------------------------------------------------------
    // Core

    io_core core (
        .clock         (clock),
        .arst_n        (arst_n),
        .frame         (frame),
        .frame_strobe  (frame_strobe),
        .result        (result),
        .result_strobe (result_strobe)
    );

    // ----------------------------------------------------------------------
    // Serial out

    harness_output_register output_reg (
        .clock         (clock),
        .arst_n        (arst_n),
        .result        (result),
        .result_strobe (result_strobe),
        .test_out      (test_out)
    );

endmodule

//--- verif/harness_tb.sv
`timescale 1ns/1ps

module harness_tb;

    localparam int frame_total    = 40;
    localparam int clock_half     = 20;
    localparam int drive_delay    = 2;
    localparam int reset_cycles   = 16;
    localparam int in_bits        = harness_pkg::in_frame_width;
    localparam int out_bits       = harness_pkg::out_frame_width;
    // Last input bit sampled to first output bit shown
    localparam int load_offset    = 3;
    localparam int timeout_cycles = (frame_total + 2) * in_bits + reset_cycles + 100;

    typedef logic [in_bits-1:0]  in_vec_t;
    typedef logic [out_bits-1:0] out_vec_t;

    logic        clock;
    logic        arst_n;
    logic        test_in;
    logic        test_out;
    logic [15:0] lfsr_state = 16'd36;
    int          cycle_count = 0;

    harness_pkg::harness_in_t  frames_sent [frame_total];
    harness_pkg::harness_out_t expected_q [$];

    test_harness UUT (
        .clock    (clock),
        .arst_n   (arst_n),
        .test_in  (test_in),
        .test_out (test_out)
    );

    initial begin
        clock = 1'b0;
        forever #clock_half clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic harness_pkg::harness_in_t random_frame(input int idx);
        in_vec_t                  bits;
        harness_pkg::harness_in_t f;
        for (int i = in_bits - 1; i >= 0; i--) begin
            bits[i] = lfsr_bit();
        end
        f = bits;
        if (idx < 4) begin
            f.op = harness_pkg::alu_op_t'(idx);
        end
        // Corner cases once the first frames have covered each op
        if (idx >= 8) begin
            case (idx % 8)
                1: f.side_a.read_ef = '0;
                2: f.side_b.read_ef = '0;
                3: f.side_a.write_ef = '1;
                4: f.side_b.write_ef = '1;
                5: begin
                    f.side_a.read_ef = '0;
                    f.side_b.read_ef = '0;
                end
                6: begin
                    f.side_a.read_ef  = 4'b1000;
                    f.side_a.write_ef = 4'b0111;
                    f.side_b.read_ef  = 4'b0100;
                    f.side_b.write_ef = 4'b1011;
                end
                default: ;
            endcase
        end
        return f;
    endfunction

    // ----------------------------------------------------------------------
    // Reference model

    // -1 when no flag is set
    function automatic int lowest_port(input logic [3:0] flags);
        int idx;
        idx = -1;
        for (int i = 0; i < harness_pkg::port_count; i++) begin
            if (flags[i] && idx < 0) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic harness_pkg::word_t apply_op(
        input harness_pkg::alu_op_t op,
        input harness_pkg::word_t   x,
        input harness_pkg::word_t   y
    );
        logic [harness_pkg::word_width:0] diff;
        diff = {1'b0, x} - {1'b0, y};
        case (op)
            harness_pkg::op_add: return x + y;
            harness_pkg::op_sub: return diff[harness_pkg::word_width-1:0];
            harness_pkg::op_and: return x & y;
            default:             return x ^ y;
        endcase
    endfunction

    function automatic harness_pkg::harness_out_t model_result(
        input harness_pkg::harness_in_t f
    );
        harness_pkg::harness_out_t r;
        int                        ra;
        int                        rb;
        int                        wa;
        int                        wb;
        r  = '0;
        ra = lowest_port(f.side_a.read_ef);
        rb = lowest_port(f.side_b.read_ef);
        wa = lowest_port(~f.side_a.write_ef);
        wb = lowest_port(~f.side_b.write_ef);
        if (ra >= 0) begin
            r.rden_a[ra] = 1'b1;
        end
        if (rb >= 0) begin
            r.rden_b[rb] = 1'b1;
        end
        if (ra >= 0 && rb >= 0) begin
            if (wa >= 0) begin
                r.wren_a[wa]       = 1'b1;
                r.write_data_a[wa] = apply_op(f.op, f.side_a.read_data[ra],
                                              f.side_b.read_data[rb]);
            end
            if (wb >= 0) begin
                r.wren_b[wb]       = 1'b1;
                r.write_data_b[wb] = apply_op(f.op, f.side_b.read_data[rb],
                                              f.side_a.read_data[ra]);
            end
        end
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Checking

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_field(input string name, input out_vec_t expected,
                               input out_vec_t actual);
        assert (actual === expected) else
            stop_on_failure($sformatf("** Error at time %0t: field %s expected %0h got %0h",
                                      $time, name, expected, actual));
    endtask

    task automatic check_frame(input harness_pkg::harness_out_t expected,
                               input out_vec_t captured);
        harness_pkg::harness_out_t got;
        got = captured;
        check_field("rden_a", out_vec_t'(expected.rden_a), out_vec_t'(got.rden_a));
        check_field("rden_b", out_vec_t'(expected.rden_b), out_vec_t'(got.rden_b));
        check_field("wren_a", out_vec_t'(expected.wren_a), out_vec_t'(got.wren_a));
        check_field("wren_b", out_vec_t'(expected.wren_b), out_vec_t'(got.wren_b));
        check_field("write_data_a", out_vec_t'(expected.write_data_a),
                    out_vec_t'(got.write_data_a));
        check_field("write_data_b", out_vec_t'(expected.write_data_b),
                    out_vec_t'(got.write_data_b));
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            stop_on_failure($sformatf("Timeout: run did not finish within %0d clock cycles",
                                      timeout_cycles));
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence

    initial begin
        int                        rel;
        int                        fidx;
        int                        bit_idx;
        out_vec_t                  captured;
        harness_pkg::harness_out_t expected;

        arst_n   = 1'b0;
        test_in  = 1'b0;
        captured = '0;
        for (int f = 0; f < frame_total; f++) begin
            frames_sent[f] = random_frame(f);
        end

        repeat (reset_cycles) begin
            @(posedge clock);
            #drive_delay;
            assert (test_out === 1'b0) else
                stop_on_failure($sformatf("** Error at time %0t: test_out high in reset",
                                          $time));
        end
        arst_n = 1'b1;

        // One bit in and one bit out per cycle with frames back to back
        for (int c = 0; c <= (frame_total + 1) * in_bits; c++) begin
            if (c < frame_total * in_bits) begin
                fidx    = c / in_bits;
                bit_idx = c % in_bits;
                test_in = frames_sent[fidx][in_bits - 1 - bit_idx];
                if (bit_idx == in_bits - 1) begin
                    expected_q.push_back(model_result(frames_sent[fidx]));
                end
            end else begin
                test_in = 1'b0;
            end

            rel = c - in_bits - load_offset;
            if (rel < 0) begin
                assert (test_out === 1'b0) else
                    stop_on_failure($sformatf(
                        "** Error at time %0t: test_out high before first load", $time));
            end else begin
                bit_idx = rel % in_bits;
                if (bit_idx < out_bits) begin
                    captured[out_bits - 1 - bit_idx] = test_out;
                    if (bit_idx == out_bits - 1) begin
                        expected = expected_q.pop_front();
                        check_frame(expected, captured);
                    end
                end else begin
                    // Gap between frames must be zero fill
                    assert (test_out === 1'b0) else
                        stop_on_failure($sformatf(
                            "** Error at time %0t: test_out high between frames", $time));
                end
            end

            @(posedge clock);
            #drive_delay;
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- project.f
common/harness_pkg.sv
src/harness_input_register.sv
src/harness_output_register.sv
io_core/io_side_picker.sv
io_core/io_combiner.sv
io_core/io_core.sv
src/test_harness.sv
verif/harness_tb.sv

//--- Makefile
# Verilator build and run for the serial test harness

VERILATOR ?= verilator
TOP       ?= harness_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of the binary
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
